/* rtl/htu_pkg.sv */
package htu_pkg;

  localparam int TAG_W    = 22;
  localparam int IDX_W    = 3;
  localparam int NUM_SETS = 8;
  localparam int NUM_WAYS = 2;

  // address layout is tag, then set index, then the half select bit
  localparam int TAG_LSB = 32 - TAG_W;
  localparam int IDX_LSB = TAG_LSB - IDX_W;
  localparam int OFS_BIT = IDX_LSB - 1;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE,
    OP_FLUSH,
    OP_INVALIDATE
  } htu_op_e;

  // EMPTY means the half has not been fetched since allocation
  typedef enum logic [1:0] {
    OFS_EMPTY,
    OFS_CLEAN,
    OFS_DIRTY
  } ofs_state_e;

  typedef struct packed {
    htu_op_e     op;
    logic [31:0] addr;
  } htu_req_t;

  typedef struct packed {
    logic             hit;
    logic             way;
    ofs_state_e       ofs0;
    ofs_state_e       ofs1;
    logic             evict_valid;
    logic [TAG_W-1:0] evict_tag;
    logic [1:0]       evict_dirty;
    logic [1:0]       wb_mask;
    logic [TAG_W-1:0] tag;
  } htu_rsp_t;

  // next state of one half, shared by the half's register and the set's response
  function automatic ofs_state_e ofs_next(
    input ofs_state_e cur,
    input logic       accessed,
    input logic       is_read,
    input logic       is_write,
    input logic       is_flush,
    input logic       is_inval,
    input logic       line_hit,
    input logic       allocate
  );
    ofs_state_e nxt;
    nxt = cur;
    if (allocate) begin
      if (!accessed)
        nxt = OFS_EMPTY;
      else if (is_write)
        nxt = OFS_DIRTY;
      else
        nxt = OFS_CLEAN;
    end else if (line_hit) begin
      // flush and invalidate act on both halves
      if (is_inval)
        nxt = OFS_EMPTY;
      else if (is_flush && cur == OFS_DIRTY)
        nxt = OFS_CLEAN;
      else if (accessed && is_write)
        nxt = OFS_DIRTY;
      else if (accessed && is_read && cur == OFS_EMPTY)
        nxt = OFS_CLEAN;
    end
    return nxt;
  endfunction

endpackage

/* rtl/bank_htu_offset.sv */
module bank_htu_offset (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                offset_hit_i,
  input  logic                op_is_read_i,
  input  logic                op_is_write_i,
  input  logic                op_is_flush_i,
  input  logic                op_is_invalidate_i,
  input  logic                cacheline_hit_i,
  input  logic                cacheline_allocate_i,
  output htu_pkg::ofs_state_e offset_status_o
);
  import htu_pkg::*;

  ofs_state_e state_q;
  ofs_state_e state_d;

  // allocate wins over the line hit, the two never come together anyway
  assign state_d = ofs_next(state_q,
                            offset_hit_i,
                            op_is_read_i,
                            op_is_write_i,
                            op_is_flush_i,
                            op_is_invalidate_i,
                            cacheline_hit_i,
                            cacheline_allocate_i);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= OFS_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  assign offset_status_o = state_q;

endmodule

/* rtl/bank_htu_cacheline.sv */
module bank_htu_cacheline (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      set_hit_i,
  input  logic                      op_is_read_i,
  input  logic                      op_is_write_i,
  input  logic                      op_is_flush_i,
  input  logic                      op_is_invalidate_i,
  input  logic                      access_offset1_i,
  input  logic [htu_pkg::TAG_W-1:0] access_tag_i,
  input  logic                      cacheline_allocate_i,
  output logic                      cacheline_valid_o,
  output logic                      cacheline_hit_o,
  output logic [htu_pkg::TAG_W-1:0] cacheline_tag_o,
  output htu_pkg::ofs_state_e       offset0_state_o,
  output htu_pkg::ofs_state_e       offset1_state_o
);
  import htu_pkg::*;

  logic             valid_q;
  logic [TAG_W-1:0] tag_q;
  logic             line_hit;

  assign cacheline_valid_o = valid_q;
  assign cacheline_tag_o   = tag_q;
  assign cacheline_hit_o   = valid_q && (access_tag_i == tag_q);

  // only a hit in the selected set may touch the halves
  assign line_hit = set_hit_i && cacheline_hit_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (cacheline_allocate_i) begin
      valid_q <= 1'b1;
    end else if (line_hit && op_is_invalidate_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cacheline_allocate_i) begin
      tag_q <= access_tag_i;
    end
  end

  bank_htu_offset offset0_i (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .offset_hit_i        (!access_offset1_i),
    .op_is_read_i        (op_is_read_i),
    .op_is_write_i       (op_is_write_i),
    .op_is_flush_i       (op_is_flush_i),
    .op_is_invalidate_i  (op_is_invalidate_i),
    .cacheline_hit_i     (line_hit),
    .cacheline_allocate_i(cacheline_allocate_i),
    .offset_status_o     (offset0_state_o)
  );

  bank_htu_offset offset1_i (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .offset_hit_i        (access_offset1_i),
    .op_is_read_i        (op_is_read_i),
    .op_is_write_i       (op_is_write_i),
    .op_is_flush_i       (op_is_flush_i),
    .op_is_invalidate_i  (op_is_invalidate_i),
    .cacheline_hit_i     (line_hit),
    .cacheline_allocate_i(cacheline_allocate_i),
    .offset_status_o     (offset1_state_o)
  );

endmodule

/* rtl/bank_htu_set.sv */
module bank_htu_set (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              sel_i,
  input  htu_pkg::htu_req_t req_i,
  output htu_pkg::htu_rsp_t rsp_o
);
  import htu_pkg::*;

  logic                op_is_read;
  logic                op_is_write;
  logic                op_is_flush;
  logic                op_is_invalidate;
  logic [TAG_W-1:0]    req_tag;
  logic                req_ofs1;
  logic [NUM_WAYS-1:0] way_valid;
  logic [NUM_WAYS-1:0] way_hit;
  logic [NUM_WAYS-1:0] way_alloc;
  logic [TAG_W-1:0]    way_tag [NUM_WAYS];
  ofs_state_e          way_ofs0 [NUM_WAYS];
  ofs_state_e          way_ofs1 [NUM_WAYS];
  logic [1:0]          way_dirty [NUM_WAYS];
  logic                hit;
  logic                alloc;
  logic                lru_q;
  logic                rsp_way;

  assign op_is_read       = (req_i.op == OP_READ);
  assign op_is_write      = (req_i.op == OP_WRITE);
  assign op_is_flush      = (req_i.op == OP_FLUSH);
  assign op_is_invalidate = (req_i.op == OP_INVALIDATE);

  assign req_tag  = req_i.addr[TAG_LSB +: TAG_W];
  assign req_ofs1 = req_i.addr[OFS_BIT];

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    assign way_alloc[w] = alloc && (lru_q == 1'(w));
    assign way_dirty[w] = {way_ofs1[w] == OFS_DIRTY, way_ofs0[w] == OFS_DIRTY};

    bank_htu_cacheline line_i (
      .clk_i               (clk_i),
      .rst_i               (rst_i),
      .set_hit_i           (sel_i),
      .op_is_read_i        (op_is_read),
      .op_is_write_i       (op_is_write),
      .op_is_flush_i       (op_is_flush),
      .op_is_invalidate_i  (op_is_invalidate),
      .access_offset1_i    (req_ofs1),
      .access_tag_i        (req_tag),
      .cacheline_allocate_i(way_alloc[w]),
      .cacheline_valid_o   (way_valid[w]),
      .cacheline_hit_o     (way_hit[w]),
      .cacheline_tag_o     (way_tag[w]),
      .offset0_state_o     (way_ofs0[w]),
      .offset1_state_o     (way_ofs1[w])
    );
  end

  // at most one way can match since a line is only allocated on a miss
  assign hit     = |way_hit;
  assign alloc   = sel_i && !hit && (op_is_read || op_is_write);
  assign rsp_way = hit ? way_hit[1] : lru_q;

  // lru_q names the way that is replaced next
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      lru_q <= 1'b0;
    end else if (sel_i && (op_is_read || op_is_write)) begin
      lru_q <= !rsp_way;
    end
  end

  always_comb begin
    rsp_o      = '0;
    rsp_o.hit  = hit;
    rsp_o.way  = rsp_way;
    rsp_o.tag  = req_tag;
    // report the halves as they look after this request
    rsp_o.ofs0 = ofs_next(way_ofs0[rsp_way], !req_ofs1, op_is_read, op_is_write,
                          op_is_flush, op_is_invalidate, hit, alloc);
    rsp_o.ofs1 = ofs_next(way_ofs1[rsp_way], req_ofs1, op_is_read, op_is_write,
                          op_is_flush, op_is_invalidate, hit, alloc);
    if (alloc && way_valid[lru_q]) begin
      rsp_o.evict_valid = 1'b1;
      rsp_o.evict_tag   = way_tag[lru_q];
      rsp_o.evict_dirty = way_dirty[lru_q];
    end
    if (hit && op_is_flush) begin
      rsp_o.wb_mask = way_dirty[rsp_way];
    end
  end

endmodule

/* rtl/bank_htu.sv */
module bank_htu (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_valid_i,
  input  htu_pkg::htu_req_t req_i,
  output logic              rsp_valid_o,
  output htu_pkg::htu_rsp_t rsp_o
);
  import htu_pkg::*;

  logic [IDX_W-1:0]    req_idx;
  logic [NUM_SETS-1:0] set_sel;
  htu_rsp_t            set_rsp [NUM_SETS];
  htu_rsp_t            rsp_d;

  assign req_idx = req_i.addr[IDX_LSB +: IDX_W];

  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    assign set_sel[s] = req_valid_i && (req_idx == IDX_W'(s));

    bank_htu_set set_i (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .sel_i(set_sel[s]),
      .req_i(req_i),
      .rsp_o(set_rsp[s])
    );
  end

  // every set sees the request, only the indexed one updates or answers
  assign rsp_d = set_rsp[req_idx];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_o <= rsp_d;
    end
  end

endmodule

/* tb/bank_htu_props.sv */
module bank_htu_props (
  input logic              clk_i,
  input logic              rst_i,
  input logic              req_valid_i,
  input logic              rsp_valid_o,
  input htu_pkg::htu_rsp_t rsp_o
);

  // the response register adds exactly one cycle of latency
  rsp_follows_req: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |=> rsp_valid_o)
    else $error("no response one cycle after a request");

  no_rsp_without_req: assert property (@(posedge clk_i) disable iff (rst_i)
    !req_valid_i |=> !rsp_valid_o)
    else $error("response valid without a request one cycle before");

  // a victim is only reported when a miss allocates
  no_hit_with_evict: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o |-> !(rsp_o.hit && rsp_o.evict_valid))
    else $error("response shows a hit together with an eviction");

  quiet_in_reset: assert property (@(posedge clk_i)
    rst_i |-> !rsp_valid_o)
    else $error("response valid while reset is asserted");

endmodule

bind bank_htu bank_htu_props props_i (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .req_valid_i(req_valid_i),
  .rsp_valid_o(rsp_valid_o),
  .rsp_o      (rsp_o)
);

/* tb/bank_htu_tb.sv */
module bank_htu_tb;
  import htu_pkg::*;

  localparam int MIX_REQS = 200;
  // directed tests need under 60 cycles, reset 8, the mixed stream one per request
  localparam int MAX_CYCLES = 600;

  logic     clk_i;
  logic     rst_i;
  logic     req_valid;
  htu_req_t req;
  logic     rsp_valid;
  htu_rsp_t rsp;
  htu_rsp_t exp_rsp;
  int       cycles = 0;
  int       seed = 83;

  // reference model of the tags and half states, indexed by set and way
  logic             m_valid [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0] m_tag   [NUM_SETS][NUM_WAYS];
  ofs_state_e       m_ofs   [NUM_SETS][NUM_WAYS][2];
  logic             m_lru   [NUM_SETS];

  bank_htu bank_htu_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_valid_i(req_valid),
    .req_i      (req),
    .rsp_valid_o(rsp_valid),
    .rsp_o      (rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  task automatic report_error(input string msg);
    $display("ERR @%0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input htu_rsp_t got, input htu_rsp_t exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s: response %h, expected %h", what, got, exp));
  endtask

  task automatic check_ofs(input ofs_state_e got, input ofs_state_e exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s: half state %s, expected %s", what, got.name(), exp.name()));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  function automatic logic [31:0] addr_of(input logic [21:0] tag, input logic [2:0] idx,
                                          input logic ofs1);
    return {tag, idx, ofs1, 6'b0};
  endfunction

  // applies one request to the model and returns the response it predicts
  task automatic model_step(input htu_req_t r, output htu_rsp_t exp);
    logic [2:0]  idx;
    logic [21:0] tag;
    logic        ofs1;
    logic        rw;
    logic        way;
    exp  = '0;
    idx  = r.addr[9:7];
    tag  = r.addr[31:10];
    ofs1 = r.addr[6];
    rw   = (r.op == OP_READ) || (r.op == OP_WRITE);
    way  = m_lru[idx];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        exp.hit = 1'b1;
        way     = w[0];
      end
    end
    if (!exp.hit && rw) begin
      if (m_valid[idx][way]) begin
        exp.evict_valid = 1'b1;
        exp.evict_tag   = m_tag[idx][way];
        exp.evict_dirty = {m_ofs[idx][way][1] == OFS_DIRTY, m_ofs[idx][way][0] == OFS_DIRTY};
      end
      m_valid[idx][way]     = 1'b1;
      m_tag[idx][way]       = tag;
      m_ofs[idx][way][ofs1] = (r.op == OP_WRITE) ? OFS_DIRTY : OFS_CLEAN;
      m_ofs[idx][way][!ofs1] = OFS_EMPTY;
    end else if (exp.hit) begin
      case (r.op)
        OP_READ: begin
          if (m_ofs[idx][way][ofs1] == OFS_EMPTY)
            m_ofs[idx][way][ofs1] = OFS_CLEAN;
        end
        OP_WRITE: m_ofs[idx][way][ofs1] = OFS_DIRTY;
        OP_FLUSH: begin
          for (int h = 0; h < 2; h++) begin
            exp.wb_mask[h] = (m_ofs[idx][way][h] == OFS_DIRTY);
            if (m_ofs[idx][way][h] == OFS_DIRTY)
              m_ofs[idx][way][h] = OFS_CLEAN;
          end
        end
        default: begin
          m_valid[idx][way]  = 1'b0;
          m_ofs[idx][way][0] = OFS_EMPTY;
          m_ofs[idx][way][1] = OFS_EMPTY;
        end
      endcase
    end
    if (rw)
      m_lru[idx] = !way;
    exp.way  = way;
    exp.tag  = tag;
    exp.ofs0 = m_ofs[idx][way][0];
    exp.ofs1 = m_ofs[idx][way][1];
  endtask

  // drives one request and checks its response one cycle later, valid stays high
  task automatic issue_req(input htu_op_e op, input logic [31:0] addr);
    req.op    = op;
    req.addr  = addr;
    req_valid = 1'b1;
    model_step(req, exp_rsp);
    @(posedge clk_i);
    #1;
    check_bit(rsp_valid, 1'b1, "response valid");
    check_rsp(rsp, exp_rsp, $sformatf("%s of %h", op.name(), addr));
  endtask

  task automatic go_idle();
    req_valid = 1'b0;
    @(posedge clk_i);
    #1;
    check_bit(rsp_valid, 1'b0, "response valid while idle");
  endtask

  task automatic after_reset_read();
    issue_req(OP_READ, addr_of(22'h1, 3'd0, 1'b0));
    check_bit(rsp.hit, 1'b0, "first read hit");
    check_bit(rsp.way, 1'b0, "first read way");
    check_bit(rsp.evict_valid, 1'b0, "first read evict valid");
    check_ofs(rsp.ofs0, OFS_CLEAN, "first read half 0");
    check_ofs(rsp.ofs1, OFS_EMPTY, "first read half 1");
    go_idle();
  endtask

  task automatic read_then_write();
    issue_req(OP_READ, addr_of(22'h1, 3'd0, 1'b0));
    check_bit(rsp.hit, 1'b1, "second read hit");
    issue_req(OP_WRITE, addr_of(22'h1, 3'd0, 1'b1));
    check_ofs(rsp.ofs0, OFS_CLEAN, "write half 0");
    check_ofs(rsp.ofs1, OFS_DIRTY, "write half 1");
    go_idle();
  endtask

  task automatic flush_lines();
    issue_req(OP_FLUSH, addr_of(22'h1, 3'd0, 1'b0));
    check_bit(rsp.wb_mask == 2'b10, 1'b1, "flush writeback mask");
    check_ofs(rsp.ofs1, OFS_CLEAN, "flushed half 1");
    issue_req(OP_FLUSH, addr_of(22'h1, 3'd0, 1'b1));
    check_bit(rsp.wb_mask == 2'b00, 1'b1, "second flush mask");
    issue_req(OP_FLUSH, addr_of(22'h2, 3'd0, 1'b0));
    check_bit(rsp.hit, 1'b0, "flush miss hit");
    issue_req(OP_READ, addr_of(22'h2, 3'd0, 1'b0));
    check_bit(rsp.hit, 1'b0, "read after flush miss");
    go_idle();
  endtask

  task automatic invalidate_line();
    issue_req(OP_INVALIDATE, addr_of(22'h1, 3'd0, 1'b0));
    check_bit(rsp.hit, 1'b1, "invalidate hit");
    issue_req(OP_READ, addr_of(22'h1, 3'd0, 1'b1));
    check_bit(rsp.hit, 1'b0, "read after invalidate");
    check_ofs(rsp.ofs1, OFS_CLEAN, "realloc half 1");
    go_idle();
  endtask

  task automatic lru_replace();
    issue_req(OP_WRITE, addr_of(22'h3a, 3'd3, 1'b0));
    issue_req(OP_READ, addr_of(22'h3b, 3'd3, 1'b0));
    issue_req(OP_READ, addr_of(22'h3a, 3'd3, 1'b1));
    issue_req(OP_READ, addr_of(22'h3c, 3'd3, 1'b0));
    check_bit(rsp.evict_valid, 1'b1, "first victim valid");
    check_bit(rsp.evict_tag == 22'h3b, 1'b1, "first victim tag");
    issue_req(OP_READ, addr_of(22'h3b, 3'd3, 1'b0));
    check_bit(rsp.evict_tag == 22'h3a, 1'b1, "second victim tag");
    check_bit(rsp.evict_dirty == 2'b01, 1'b1, "second victim dirty mask");
    go_idle();
  endtask

  task automatic mixed_stream();
    logic [21:0] tag_pool [4];
    logic [31:0] r;
    tag_pool = '{22'h2a, 22'h15, 22'h3c7, 22'h100};
    for (int i = 0; i < MIX_REQS; i++) begin
      r = $random(seed);
      issue_req(htu_op_e'(r[1:0]), addr_of(tag_pool[r[3:2]], r[4] ? 3'd6 : 3'd5, r[5]));
    end
    go_idle();
  endtask

  initial begin
    for (int s = 0; s < NUM_SETS; s++) begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w]  = 1'b0;
        m_ofs[s][w][0] = OFS_EMPTY;
        m_ofs[s][w][1] = OFS_EMPTY;
      end
    end
    rst_i     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_bit(rsp_valid, 1'b0, "response valid after reset");
    after_reset_read();
    read_then_write();
    flush_lines();
    invalidate_line();
    lru_replace();
    mixed_stream();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* build.f */
rtl/htu_pkg.sv
rtl/bank_htu_offset.sv
rtl/bank_htu_cacheline.sv
rtl/bank_htu_set.sv
rtl/bank_htu.sv
tb/bank_htu_props.sv
tb/bank_htu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bank_htu_tb -f build.f
output=$(./obj_dir/Vbank_htu_tb)
echo "$output"

if grep -qFx "PASS: all tests" <<< "$output"; then
  exit 0
fi
exit 1
